// File: heapTop.f
src/heapPkg.sv
src/pipePkg.sv
src/allocStage.sv
src/sizeStage.sv
src/elementStage.sv
src/heapTop.sv
verif/heapTb.sv

// File: verif/heapTb.sv
//--------------------------------------------------------------------
// Testbench for the array heap. Drives directed and random requests,
// predicts each result with a behavioral model and compares the DUT
// output three cycles later. Run with the heapTop file list.
//--------------------------------------------------------------------
module heapTb import heapPkg::*, pipePkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int directedRequests = 69;            // Sum of the directed tests
  localparam int randomRequests   = 600;           // Back to back random mix
  localparam int timeoutCycles    = (directedRequests + randomRequests) * 10 + 100;

  logic        clock;
  logic        reset;
  logic        requestValid;
  heapRequestT request;
  logic        resultValid;
  heapResultT  result;

  heapResultT  expQ [$];                           // Expected results in order
  bit          knownQ [$];                         // Data word is predictable
  string       nameQ [$];                          // Test that issued it
  int unsigned dueQ [$];                           // Cycle each result is due
  int unsigned cycleCount = 0;                     // Rising edges since start
  logic [31:0] rngState = 32'h57da_363b;

  // Model state
  bit          isAllocated [arrayCount];
  arrayIdT     freeList [$];                       // Back is the stack top
  int          freshNext;
  int          sizeOf [arrayCount];
  elemDataT    elems [arrayCount][arrayLength];
  bit          written [arrayCount][arrayLength];  // Slot holds a defined value

  heapTop heapTop_i (
    .clock, .reset, .requestValid, .request, .resultValid, .result
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;                     // 10 ns period
  end

  always @(posedge clock) cycleCount <= cycleCount + 1;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //------------------------------------------------------------------
  // Reference model, one call per request in issue order
  //------------------------------------------------------------------
  function automatic heapResultT applyModel(heapRequestT req, output bit dataKnown);
    heapResultT res;
    elemDataT   oldValue;
    elemDataT   newValue;
    int         a;
    int         i;
    a         = int'(req.array);
    i         = int'(req.index);
    res       = '{data: '0, error: errNone};
    dataKnown = 1'b1;
    if (req.op == opAlloc) begin
      if (freeList.size() != 0) begin
        a = int'(freeList.pop_back());             // Last freed comes back first
      end else if (freshNext < arrayCount) begin
        a = freshNext;
        freshNext++;
      end else begin
        res.error = errOutOfMemory;
        return res;
      end
      isAllocated[a] = 1'b1;
      sizeOf[a]      = 0;
      res.data       = elemDataT'(a);
      return res;
    end
    if (!isAllocated[a]) begin
      res.error = errNotAllocated;                 // No state change
      return res;
    end
    case (req.op)
      opFree: begin
        isAllocated[a] = 1'b0;
        freeList.push_back(req.array);
      end
      opWrite: begin
        elems[a][i]   = req.data;
        written[a][i] = 1'b1;
        if (i >= sizeOf[a]) sizeOf[a] = i + 1;     // Grow to cover the index
        res.data = req.data;
      end
      opSize: res.data = elemDataT'(sizeOf[a]);
      opPush: begin
        if (sizeOf[a] == arrayLength) begin
          res.error = errFull;
        end else begin
          elems[a][sizeOf[a]]   = req.data;
          written[a][sizeOf[a]] = 1'b1;
          sizeOf[a]++;
          res.data = req.data;
        end
      end
      opPop: begin
        if (sizeOf[a] == 0) begin
          res.error = errEmpty;
        end else begin
          sizeOf[a]--;
          res.data  = elems[a][sizeOf[a]];
          dataKnown = written[a][sizeOf[a]];
        end
      end
      default: begin                               // Read and the updates
        if (i >= sizeOf[a]) begin
          res.error = errOutOfBounds;
        end else begin
          oldValue = elems[a][i];
          case (req.op)
            opAdd, opAddAfter: newValue = oldValue + req.data;
            opSub, opSubAfter: newValue = oldValue - req.data;
            opOr:              newValue = oldValue | req.data;
            opXor:             newValue = oldValue ^ req.data;
            opAnd:             newValue = oldValue & req.data;
            default:           newValue = oldValue;  // Plain read
          endcase
          elems[a][i] = newValue;
          dataKnown   = written[a][i];
          if (req.op == opRead || req.op == opAddAfter || req.op == opSubAfter) begin
            res.data = oldValue;
          end else begin
            res.data = newValue;
          end
        end
      end
    endcase
    return res;
  endfunction

  //------------------------------------------------------------------
  // Stimulus and checks
  //------------------------------------------------------------------
  task automatic issue(heapOpT op, arrayIdT array, elemIndexT index, elemDataT data,
                       string testName);
    heapRequestT req;
    heapResultT  expected;
    bit          known;
    req      = '{op: op, array: array, index: index, data: data};
    expected = applyModel(req, known);
    @(posedge clock);
    requestValid <= 1'b1;
    request      <= req;
    expQ.push_back(expected);
    knownQ.push_back(known);
    nameQ.push_back(testName);
    dueQ.push_back(cycleCount + 4);                // Counter lags this edge by one
  endtask

  task automatic idle();
    @(posedge clock);
    requestValid <= 1'b0;
    request      <= '0;
  endtask

  task automatic checkData(string testName, elemDataT expected, elemDataT actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: data expected %h, actual %h", testName, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic checkError(string testName, heapErrorT expected, heapErrorT actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: error expected %s, actual %s (%0d)", testName,
               expected.name(), actual.name(), actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "error code mismatch");
    end
  endtask

  // Outputs are stable mid cycle
  always @(negedge clock) begin : compareResults
    heapResultT  expected;
    bit          known;
    string       testName;
    int unsigned due;
    if (!reset && resultValid) begin
      if (expQ.size() == 0) begin
        $display("Unexpected result: DUT produced a result with no request outstanding");
        $display("*** TEST FAILED ***");
        $fatal(1, "unexpected result");
      end else begin
        expected = expQ.pop_front();
        known    = knownQ.pop_front();
        testName = nameQ.pop_front();
        due      = dueQ.pop_front();
        if (cycleCount != due) begin
          $display("Result for %s came at cycle %0d, three cycles after its request is %0d",
                   testName, cycleCount, due);
          $display("*** TEST FAILED ***");
          $fatal(1, "result latency wrong");
        end
        checkError(testName, expected.error, result.error);
        if (known) checkData(testName, expected.data, result.data);  // Skip unwritten slots
      end
    end
  end

  initial begin : watchdog
    repeat (timeoutCycles) @(posedge clock);
    $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin : runTests
    logic [3:0] opCode;
    reset        = 1'b1;
    requestValid = 1'b0;
    request      = '0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    // Never allocated arrays reject everything
    issue(opRead, 3'd6, 3'd0, 16'h0000, "notAllocated");
    issue(opFree, 3'd6, 3'd0, 16'h0000, "notAllocated");
    issue(opSize, 3'd6, 3'd0, 16'h0000, "notAllocated");

    // Fresh numbers in order, then LIFO reuse
    for (int k = 0; k < 9; k++) issue(opAlloc, 3'd0, 3'd0, 16'h0000, "allocOrder");
    issue(opFree, 3'd2, 3'd0, 16'h0000, "allocOrder");
    issue(opFree, 3'd5, 3'd0, 16'h0000, "allocOrder");
    issue(opAlloc, 3'd0, 3'd0, 16'h0000, "allocOrder");
    issue(opAlloc, 3'd0, 3'd0, 16'h0000, "allocOrder");

    issue(opWrite, 3'd0, 3'd0, 16'h1234, "writeRead");
    issue(opRead,  3'd0, 3'd0, 16'h0000, "writeRead");
    issue(opWrite, 3'd0, 3'd5, 16'hbeef, "writeRead");  // Grows size to 6
    issue(opSize,  3'd0, 3'd0, 16'h0000, "writeRead");
    issue(opRead,  3'd0, 3'd5, 16'h0000, "writeRead");
    issue(opRead,  3'd0, 3'd6, 16'h0000, "writeRead");
    issue(opRead,  3'd0, 3'd7, 16'h0000, "writeRead");

    // Ninth push and ninth pop fail
    for (int k = 0; k < 9; k++) issue(opPush, 3'd1, 3'd0, 16'h0100 + 16'(k), "pushPop");
    for (int k = 0; k < 9; k++) issue(opPop, 3'd1, 3'd0, 16'h0000, "pushPop");

    issue(opWrite,    3'd3, 3'd2, 16'hfff0, "updates");
    issue(opAdd,      3'd3, 3'd2, 16'h0020, "updates");  // Wraps to 0010
    issue(opRead,     3'd3, 3'd2, 16'h0000, "updates");
    issue(opAddAfter, 3'd3, 3'd2, 16'h0005, "updates");
    issue(opRead,     3'd3, 3'd2, 16'h0000, "updates");
    issue(opSub,      3'd3, 3'd2, 16'h0020, "updates");  // Wraps below zero
    issue(opRead,     3'd3, 3'd2, 16'h0000, "updates");
    issue(opSubAfter, 3'd3, 3'd2, 16'h0001, "updates");
    issue(opRead,     3'd3, 3'd2, 16'h0000, "updates");
    issue(opOr,       3'd3, 3'd2, 16'h0f00, "updates");
    issue(opRead,     3'd3, 3'd2, 16'h0000, "updates");
    issue(opXor,      3'd3, 3'd2, 16'hffff, "updates");
    issue(opRead,     3'd3, 3'd2, 16'h0000, "updates");
    issue(opAnd,      3'd3, 3'd2, 16'h00ff, "updates");
    issue(opRead,     3'd3, 3'd2, 16'h0000, "updates");

    // Freed array rejects everything, then comes back empty
    issue(opWrite, 3'd4, 3'd1, 16'haaaa, "notAllocated");  // Known value before the free
    issue(opFree,  3'd4, 3'd0, 16'h0000, "notAllocated");
    issue(opWrite, 3'd4, 3'd1, 16'h5555, "notAllocated");
    issue(opRead,  3'd4, 3'd0, 16'h0000, "notAllocated");
    issue(opSize,  3'd4, 3'd0, 16'h0000, "notAllocated");
    issue(opPush,  3'd4, 3'd0, 16'h7777, "notAllocated");
    issue(opPop,   3'd4, 3'd0, 16'h0000, "notAllocated");
    issue(opAdd,   3'd4, 3'd0, 16'h0001, "notAllocated");
    issue(opFree,  3'd4, 3'd0, 16'h0000, "notAllocated");  // Double free
    issue(opAlloc, 3'd0, 3'd0, 16'h0000, "notAllocated");
    issue(opSize,  3'd4, 3'd0, 16'h0000, "notAllocated");
    issue(opWrite, 3'd4, 3'd2, 16'h0042, "notAllocated");  // Size back to 3
    issue(opRead,  3'd4, 3'd1, 16'h0000, "notAllocated");  // Rejected write left no trace

    //----------------------------------------------------------------
    // Random mix, one request per cycle
    //----------------------------------------------------------------
    for (int k = 0; k < randomRequests; k++) begin
      rngState = xorshift(rngState);
      opCode   = 4'(rngState[31:24] % 14);
      if (opCode == 4'(opFree) && rngState[23]) opCode = 4'(opAlloc);  // Keep arrays live
      issue(heapOpT'(opCode), rngState[18:16], rngState[21:19], rngState[15:0], "randomMix");
    end
    idle();

    while (expQ.size() != 0) @(posedge clock);     // Drain the pipeline
    repeat (3) @(posedge clock);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: src/heapTop.sv
//--------------------------------------------------------------------
// Array heap top level. Chains the three pipeline stages; a result
// leaves exactly three cycles after its request strobe.
//--------------------------------------------------------------------
module heapTop import pipePkg::*; (
  input  logic        clock,                       // Pipeline clock
  input  logic        reset,                       // Synchronous, active high
  input  logic        requestValid,                // One cycle strobe
  input  heapRequestT request,                     // Incoming request
  output logic        resultValid,                 // Result strobe
  output heapResultT  result                       // Data and error
);

  logic        allocValid;                         // Stage 1 to stage 2
  allocRecordT allocRecord;
  logic        sizeValid;                          // Stage 2 to stage 3
  sizeRecordT  sizeRecord;

  allocStage allocStage_i (
    .clock, .reset, .requestValid, .request, .allocValid, .allocRecord
  );

  sizeStage sizeStage_i (
    .clock, .reset, .allocValid, .allocRecord, .sizeValid, .sizeRecord
  );

  elementStage elementStage_i (
    .clock, .reset, .sizeValid, .sizeRecord, .resultValid, .result
  );

endmodule

// File: src/elementStage.sv
//--------------------------------------------------------------------
// Stage 3 of the heap pipeline. Holds the element storage, applies
// writes and updates, and registers the result word and error.
//--------------------------------------------------------------------
module elementStage import heapPkg::*, pipePkg::*; (
  input  logic       clock,                        // Pipeline clock
  input  logic       reset,                        // Synchronous, active high
  input  logic       sizeValid,                    // Record from stage 2
  input  sizeRecordT sizeRecord,                   // Record with slot and size
  output logic       resultValid,                  // One cycle per request
  output heapResultT result                        // Data and error
);

  elemDataT elements [arrayCount][arrayLength];    // Element storage
  elemDataT oldValue;                              // Slot before the request
  elemDataT newValue;                              // Slot after the request
  elemDataT resultData;                            // Word to return
  logic     writeBack;                             // Slot changes

  //------------------------------------------------------------------
  // Element update and result selection
  //------------------------------------------------------------------
  always_comb begin
    oldValue  = elements[sizeRecord.array][sizeRecord.slot];
    newValue  = oldValue;
    writeBack = 1'b1;
    case (sizeRecord.op)
      opWrite, opPush:   newValue = sizeRecord.data;
      opAdd, opAddAfter: newValue = oldValue + sizeRecord.data;  // Wraps at 16 bits
      opSub, opSubAfter: newValue = oldValue - sizeRecord.data;
      opOr:              newValue = oldValue | sizeRecord.data;
      opXor:             newValue = oldValue ^ sizeRecord.data;
      opAnd:             newValue = oldValue & sizeRecord.data;
      default:           writeBack = 1'b0;         // Storage untouched
    endcase

    case (sizeRecord.op)
      opWrite, opPush:                       resultData = sizeRecord.data;
      opRead, opPop, opAddAfter, opSubAfter: resultData = oldValue;
      opSize:                                resultData = elemDataT'(sizeRecord.oldSize);
      opAlloc:                               resultData = elemDataT'(sizeRecord.array);
      opAdd, opSub, opOr, opXor, opAnd:      resultData = newValue;
      default:                               resultData = '0;  // opFree
    endcase

    if (sizeRecord.error != errNone) begin
      writeBack  = 1'b0;                           // Failed requests change nothing
      resultData = '0;
    end
  end

  // Output strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= sizeValid;
    end
  end

  // Storage and result word
  always_ff @(posedge clock) begin
    if (sizeValid && writeBack) begin
      elements[sizeRecord.array][sizeRecord.slot] <= newValue;
    end
    result <= '{data: resultData, error: sizeRecord.error};
  end

  // Reads, pops and updates stay inside the array that stage 2 checked
  assert property (@(posedge clock) disable iff (reset)
    sizeValid && sizeRecord.error == errNone &&
    sizeRecord.op inside {opRead, opPop, opAdd, opAddAfter, opSub, opSubAfter,
                          opOr, opXor, opAnd}
    |-> sizeT'(sizeRecord.slot) < sizeRecord.oldSize)
    else $error("element %0d touched past the end of array %0d", sizeRecord.slot,
                sizeRecord.array);

endmodule

// File: src/sizeStage.sv
//--------------------------------------------------------------------
// Stage 2 of the heap pipeline. Keeps the size of every array,
// checks bounds, full and empty, and picks the element slot that
// stage 3 reads and writes.
//--------------------------------------------------------------------
module sizeStage import heapPkg::*, pipePkg::*; (
  input  logic        clock,                       // Pipeline clock
  input  logic        reset,                       // Synchronous, active high
  input  logic        allocValid,                  // Record from stage 1
  input  allocRecordT allocRecord,                 // Request plus outcome
  output logic        sizeValid,                   // Record valid for stage 3
  output sizeRecordT  sizeRecord                   // Record with slot and size
);

  sizeT        sizes [arrayCount];                 // Current size of each array
  heapRequestT req;                                // Request part of the record
  sizeT        oldSize;                            // Size before this request
  sizeT        newSize;                            // Size after this request
  sizeT        indexSize;                          // Index widened to a size
  elemIndexT   slot;                               // Element to touch
  heapErrorT   error;                              // Outcome after this stage

  //------------------------------------------------------------------
  // Size rules per operation
  //------------------------------------------------------------------
  always_comb begin
    req       = allocRecord.request;
    oldSize   = sizes[req.array];
    indexSize = sizeT'(req.index);
    newSize   = oldSize;
    slot      = req.index;                         // Most ops touch their index
    error     = allocRecord.error;
    if (error == errNone) begin
      case (req.op)
        opAlloc: newSize = '0;                     // Fresh or reused, starts empty
        opWrite: begin
          if (indexSize >= oldSize) newSize = indexSize + 1'b1;  // Grow to cover
        end
        opPush: begin
          if (oldSize == sizeT'(arrayLength)) begin
            error = errFull;
          end else begin
            slot    = oldSize[indexBits-1:0];      // Append after last
            newSize = oldSize + 1'b1;
          end
        end
        opPop: begin
          if (oldSize == '0) begin
            error = errEmpty;
          end else begin
            newSize = oldSize - 1'b1;
            slot    = newSize[indexBits-1:0];      // Last element
          end
        end
        opRead, opAdd, opAddAfter, opSub, opSubAfter, opOr, opXor, opAnd: begin
          if (indexSize >= oldSize) error = errOutOfBounds;
        end
        default: ;                                 // opSize and opFree
      endcase
    end
  end

  // Size table
  always_ff @(posedge clock) begin
    if (reset) begin
      sizeValid <= 1'b0;
      sizes     <= '{default: '0};
    end else begin
      sizeValid <= allocValid;
      if (allocValid && error == errNone) sizes[req.array] <= newSize;
    end
  end

  // Outgoing record
  always_ff @(posedge clock) begin
    sizeRecord <= '{op: req.op, array: req.array, index: req.index, data: req.data,
                    error: error, slot: slot, oldSize: oldSize};
  end

  // Whatever array a record touched still fits its storage a cycle later
  assert property (@(posedge clock) disable iff (reset)
    allocValid |=> sizes[$past(allocRecord.request.array)] <= sizeT'(arrayLength))
    else $error("array size exceeds %0d", arrayLength);

endmodule

// File: src/allocStage.sv
//--------------------------------------------------------------------
// Stage 1 of the heap pipeline. Hands out arrays, takes freed ones
// back onto a stack and rejects requests on unallocated arrays.
// Freed arrays are reused last in, first out, before fresh ones.
//--------------------------------------------------------------------
module allocStage import heapPkg::*, pipePkg::*; (
  input  logic        clock,                       // Pipeline clock
  input  logic        reset,                       // Synchronous, active high
  input  logic        requestValid,                // One cycle strobe
  input  heapRequestT request,                     // Incoming request
  output logic        allocValid,                  // Record valid for stage 2
  output allocRecordT allocRecord                  // Request plus outcome
);

  typedef logic [addressBits:0] countT;            // Counts 0 to arrayCount

  logic [arrayCount-1:0] allocated;                // One bit per array
  arrayIdT               freeStack [arrayCount];   // Freed array numbers
  countT                 freeDepth;                // Entries on the stack
  countT                 stackTop;                 // Depth after a pop
  countT                 freshCount;               // Arrays ever handed out
  logic                  fromStack;                // Alloc reuses a freed array
  arrayIdT               grantId;                  // Array forwarded to stage 2
  heapErrorT             error;                    // Outcome of this stage

  //------------------------------------------------------------------
  // Allocation decision
  //------------------------------------------------------------------
  always_comb begin
    fromStack = (freeDepth != '0);
    stackTop  = freeDepth - 1'b1;
    grantId   = request.array;                     // Non alloc ops keep their array
    error     = errNone;
    if (request.op == opAlloc) begin
      if (fromStack) begin
        grantId = freeStack[stackTop[addressBits-1:0]];  // Most recently freed
      end else if (freshCount < countT'(arrayCount)) begin
        grantId = freshCount[addressBits-1:0];     // Next never used array
      end else begin
        error = errOutOfMemory;
      end
    end else if (!allocated[request.array]) begin
      error = errNotAllocated;                     // Covers double free too
    end
  end

  // Control state
  always_ff @(posedge clock) begin
    if (reset) begin
      allocValid <= 1'b0;
      allocated  <= '0;
      freeDepth  <= '0;
      freshCount <= '0;
    end else begin
      allocValid <= requestValid;
      if (requestValid && error == errNone) begin
        case (request.op)
          opAlloc: begin
            allocated[grantId] <= 1'b1;
            if (fromStack) freeDepth <= stackTop;  // Pop the stack
            else freshCount <= freshCount + 1'b1;
          end
          opFree: begin
            allocated[request.array] <= 1'b0;
            freeDepth <= freeDepth + 1'b1;         // Push, slot written below
          end
          default: ;
        endcase
      end
    end
  end

  // Stack contents and the outgoing record
  always_ff @(posedge clock) begin
    if (requestValid && error == errNone && request.op == opFree) begin
      freeStack[freeDepth[addressBits-1:0]] <= request.array;
    end
    allocRecord <= '{request: '{op: request.op, array: grantId,
                                index: request.index, data: request.data},
                     error: error};
  end

  // Only arrays once handed out can be freed, so the stack stays bounded
  assert property (@(posedge clock) disable iff (reset)
    freeDepth <= freshCount && freshCount <= countT'(arrayCount))
    else $error("free stack depth %0d with %0d arrays handed out", freeDepth, freshCount);

endmodule

// File: src/pipePkg.sv
//--------------------------------------------------------------------
// Records that travel through the heap pipeline: the request, the
// stage 1 and stage 2 records, and the result at the output.
//--------------------------------------------------------------------
package pipePkg;
  import heapPkg::*;

  typedef struct packed {
    heapOpT    op;                                 // What to do
    arrayIdT   array;                              // Which array
    elemIndexT index;                              // Which element
    elemDataT  data;                               // Operand
  } heapRequestT;

  typedef struct packed {
    heapRequestT request;                          // Array holds grant for opAlloc
    heapErrorT   error;                            // Outcome so far
  } allocRecordT;

  typedef struct packed {
    heapOpT    op;                                 // Operation
    arrayIdT   array;                              // Array number
    elemIndexT index;                              // Requested index
    elemDataT  data;                               // Operand
    heapErrorT error;                              // Outcome so far
    elemIndexT slot;                               // Element to touch in stage 3
    sizeT      oldSize;                            // Size before this request
  } sizeRecordT;

  typedef struct packed {
    elemDataT  data;                               // Zero on error
    heapErrorT error;                              // Final outcome
  } heapResultT;

endpackage

// File: src/heapPkg.sv
//--------------------------------------------------------------------
// Widths, element types and the operation and error codes of the
// array heap. Every pipeline stage and the testbench import this.
//--------------------------------------------------------------------
package heapPkg;

  //------------------------------------------------------------------
  // Geometry
  //------------------------------------------------------------------
  localparam int addressBits = 3;                  // Bits in an array number
  localparam int indexBits   = 3;                  // Bits in an element index
  localparam int dataBits    = 16;                 // Width of one element
  localparam int arrayLength = 8;                  // Elements per array
  localparam int arrayCount  = 8;                  // Arrays in the heap

  typedef logic [addressBits-1:0] arrayIdT;        // Array number
  typedef logic [indexBits-1:0]   elemIndexT;      // Index within an array
  typedef logic [indexBits:0]     sizeT;           // Array size, 0 to arrayLength
  typedef logic [dataBits-1:0]    elemDataT;       // Element or result word

  //------------------------------------------------------------------
  // Operations
  //------------------------------------------------------------------
  typedef enum logic [3:0] {
    opAlloc,                                       // Allocate an array
    opFree,                                        // Return an array for reuse
    opWrite,                                       // Write an element, may grow size
    opRead,                                        // Read an element
    opSize,                                        // Current size of an array
    opPush,                                        // Append at the end
    opPop,                                         // Remove from the end
    opAdd,                                         // Add, new value out
    opAddAfter,                                    // Add, previous value out
    opSub,                                         // Subtract, new value out
    opSubAfter,                                    // Subtract, previous value out
    opOr,                                          // Bitwise or
    opXor,                                         // Bitwise xor
    opAnd                                          // Bitwise and
  } heapOpT;

  //------------------------------------------------------------------
  // Outcome of a request
  //------------------------------------------------------------------
  typedef enum logic [2:0] {
    errNone,                                       // Request succeeded
    errNotAllocated,                               // Array not allocated or freed
    errOutOfMemory,                                // No array left to hand out
    errOutOfBounds,                                // Index at or past the size
    errFull,                                       // Push onto a full array
    errEmpty                                       // Pop from an empty array
  } heapErrorT;

endpackage
